// ==== src/alu_pkg.sv ====
package alu_pkg;

	typedef logic [31:0] word_t;	// Operand, result, HI and LO
	typedef logic [4:0]  shamt_t;	// Shift amount

	localparam int SHAMT_LSB    = 6;	// Immediate shamt position inside b
	localparam int MULDIV_STEPS = 32;	// One step per bit

	// Encoding of the ALU control field
	typedef enum logic [4:0] {
		OP_AND    = 5'b00000,
		OP_OR     = 5'b00001,
		OP_XOR    = 5'b00010,
		OP_ADDU   = 5'b00011,
		OP_SUBU   = 5'b00100,
		OP_SLTU   = 5'b00101,
		OP_SLT    = 5'b00110,
		OP_MULTU  = 5'b00111,
		OP_MULT   = 5'b01000,
		OP_SLL    = 5'b01001,
		OP_SLLV   = 5'b01010,
		OP_SRA    = 5'b01011,
		OP_SRL    = 5'b01100,
		OP_SRAV   = 5'b01101,
		OP_SRLV   = 5'b01110,
		OP_DIV    = 5'b01111,
		OP_DIVU   = 5'b10000,
		OP_MFHI   = 5'b10001,
		OP_MFLO   = 5'b10010,
		OP_BLTZ   = 5'b10011,
		OP_BLTZAL = 5'b10100,
		OP_BGTZ   = 5'b10101,
		OP_BEQZ   = 5'b10110,
		OP_BNEZ   = 5'b10111,
		OP_LUI    = 5'b11000,
		OP_JR     = 5'b11001
	} alu_op_t;

	typedef enum logic [1:0] {HS_IDLE, HS_BUSY, HS_WAIT_DROP} hs_state_t;

	typedef enum logic [1:0] {MD_IDLE, MD_RUN, MD_FIX_SIGN, MD_DONE} md_state_t;

	function automatic logic is_muldiv(input alu_op_t op);
		return (op == OP_MULTU) || (op == OP_MULT) || (op == OP_DIV) || (op == OP_DIVU);
	endfunction

endpackage

// ==== src/op_capture.sv ====
`timescale 1ns/1ps

module op_capture import alu_pkg::*; (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    in_req,
	input  alu_op_t in_op,
	input  word_t   in_a,
	input  word_t   in_b,
	output logic    in_ack,
	input  logic    free,
	output logic    start,
	output alu_op_t op,
	output word_t   a,
	output word_t   b
);

	hs_state_t state;
	logic      free_q;	// Previous free for edge detect
	logic      result_back;	// Last result fully handed off
	logic      accept;

	assign accept = (state == HS_IDLE) && in_req && free && result_back;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state       <= HS_IDLE;
			in_ack      <= 1'b0;
			start       <= 1'b0;
			free_q      <= 1'b1;
			result_back <= 1'b1;
		end else begin
			start  <= 1'b0;	// Single cycle pulse
			free_q <= free;
			if (free && !free_q)
				result_back <= 1'b1;	// Output handshake finished
			case (state)
				HS_IDLE: begin
					if (accept) begin
						in_ack      <= 1'b1;
						start       <= 1'b1;
						result_back <= 1'b0;
						state       <= HS_WAIT_DROP;
					end
				end
				HS_WAIT_DROP: begin
					if (!in_req) begin	// Source released request
						in_ack <= 1'b0;
						state  <= HS_BUSY;
					end
				end
				HS_BUSY: begin
					if (result_back)
						state <= HS_IDLE;
				end
				default: state <= HS_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin	// Operands held until next accept
			op <= in_op;
			a  <= in_a;
			b  <= in_b;
		end
	end

endmodule

// ==== src/alu_core.sv ====
`timescale 1ns/1ps

module alu_core import alu_pkg::*; (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    start,
	input  alu_op_t op,
	input  word_t   a,
	input  word_t   b,
	input  word_t   hi,
	input  word_t   lo,
	input  logic    md_done,
	output logic    res_valid,
	output word_t   res_y,
	output logic    res_zero
);

	word_t  alu_y;
	shamt_t sh_imm;
	shamt_t sh_var;
	logic   md_pend;	// Waiting on the mul/div unit

	assign sh_imm = b[SHAMT_LSB +: 5];	// shamt field of the instruction
	assign sh_var = b[4:0];

	always_comb begin
		alu_y = '0;
		case (op)
			OP_AND:  alu_y = a & b;
			OP_OR:   alu_y = a | b;
			OP_XOR:  alu_y = a ^ b;
			OP_ADDU: alu_y = a + b;
			OP_SUBU: alu_y = a - b;
			OP_SLTU: alu_y = {31'b0, a < b};
			OP_SLT:  alu_y = {31'b0, $signed(a) < $signed(b)};
			OP_SLL:  alu_y = a << sh_imm;
			OP_SLLV: alu_y = a << sh_var;
			OP_SRA:  alu_y = $signed(a) >>> sh_imm;	// Sign fill
			OP_SRL:  alu_y = a >> sh_imm;
			OP_SRAV: alu_y = $signed(a) >>> sh_var;
			OP_SRLV: alu_y = a >> sh_var;
			OP_MFHI: alu_y = hi;
			OP_MFLO: alu_y = lo;

			// Branch tests give 0 when taken
			OP_BLTZ,
			OP_BLTZAL: alu_y = ($signed(a) < 0) ? 32'd0 : 32'd1;
			OP_BGTZ:   alu_y = ($signed(a) > 0) ? 32'd0 : 32'd1;
			OP_BEQZ:   alu_y = (a == '0) ? 32'd0 : 32'd1;
			OP_BNEZ:   alu_y = (a != '0) ? 32'd0 : 32'd1;

			OP_LUI:  alu_y = b << 16;
			OP_JR:   alu_y = a;	// Target passes straight through
			default: alu_y = '0;	// Mul/div result comes from lo
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			res_valid <= 1'b0;
			md_pend   <= 1'b0;
		end else begin
			res_valid <= 1'b0;
			if (start) begin
				if (is_muldiv(op))
					md_pend <= 1'b1;
				else
					res_valid <= 1'b1;
			end else if (md_pend && md_done) begin
				md_pend   <= 1'b0;
				res_valid <= 1'b1;	// New LO is the result
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start && !is_muldiv(op)) begin
			res_y    <= alu_y;
			res_zero <= (alu_y == '0);
		end else if (md_pend && md_done) begin
			res_y    <= lo;
			res_zero <= (lo == '0);
		end
	end

endmodule

// ==== src/muldiv_unit.sv ====
`timescale 1ns/1ps

module muldiv_unit import alu_pkg::*; (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    start,
	input  alu_op_t op,
	input  word_t   a,
	input  word_t   b,
	output word_t   hi,
	output word_t   lo,
	output logic    md_done
);

	md_state_t   state;
	logic [5:0]  step_cnt;
	logic        md_start;
	logic        is_signed;
	logic        is_mul;
	word_t       mag_a;
	word_t       mag_b;

	word_t       acc_hi;	// Partial product or remainder
	word_t       acc_lo;	// Multiplier or quotient bits
	word_t       opnd;	// Multiplicand or divisor
	logic        mode_mul;
	logic        neg_q;	// Negate product or quotient
	logic        neg_r;	// Negate remainder

	logic [32:0] mul_sum;
	logic [32:0] div_shift;
	logic [32:0] div_diff;
	logic        div_ge;
	word_t       div_rem;
	logic [63:0] prod_fix;

	assign md_start  = start && is_muldiv(op) && (state == MD_IDLE);
	assign is_signed = (op == OP_MULT) || (op == OP_DIV);
	assign is_mul    = (op == OP_MULT) || (op == OP_MULTU);
	assign mag_a     = (is_signed && a[31]) ? -a : a;
	assign mag_b     = (is_signed && b[31]) ? -b : b;
	assign md_done   = (state == MD_DONE);

	always_comb begin
		mul_sum   = {1'b0, acc_hi} + (acc_lo[0] ? {1'b0, opnd} : 33'd0);
		div_shift = {acc_hi, acc_lo[31]};
		div_diff  = div_shift - {1'b0, opnd};
		div_ge    = (div_shift >= {1'b0, opnd});	// Restoring step
		div_rem   = div_ge ? div_diff[31:0] : div_shift[31:0];
		prod_fix  = neg_q ? -{acc_hi, acc_lo} : {acc_hi, acc_lo};
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state    <= MD_IDLE;
			step_cnt <= '0;
			hi       <= '0;
			lo       <= '0;
		end else begin
			case (state)
				MD_IDLE: begin
					if (md_start) begin
						step_cnt <= '0;
						state    <= MD_RUN;
					end
				end
				MD_RUN: begin
					step_cnt <= step_cnt + 6'd1;
					if (step_cnt == 6'(MULDIV_STEPS - 1))
						state <= MD_FIX_SIGN;
				end
				MD_FIX_SIGN: begin
					if (mode_mul) begin
						hi <= prod_fix[63:32];
						lo <= prod_fix[31:0];
					end else begin
						hi <= neg_r ? -acc_hi : acc_hi;	// Sign of dividend
						lo <= neg_q ? -acc_lo : acc_lo;
					end
					state <= MD_DONE;
				end
				MD_DONE: state <= MD_IDLE;
				default: state <= MD_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (md_start) begin
			mode_mul <= is_mul;
			// Divide by zero keeps an unsigned all-ones quotient
			neg_q    <= is_signed && (a[31] ^ b[31]) && (is_mul || b != '0);
			neg_r    <= is_signed && a[31];
			acc_hi   <= '0;
			acc_lo   <= is_mul ? mag_b : mag_a;
			opnd     <= is_mul ? mag_a : mag_b;
		end else if (state == MD_RUN) begin
			if (mode_mul) begin
				{acc_hi, acc_lo} <= {mul_sum, acc_lo[31:1]};
			end else begin
				acc_hi <= div_rem;
				acc_lo <= {acc_lo[30:0], div_ge};	// Shift in quotient bit
			end
		end
	end

endmodule

// ==== src/result_sender.sv ====
`timescale 1ns/1ps

module result_sender import alu_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  res_valid,
	input  word_t res_y,
	input  logic  res_zero,
	output logic  out_req,
	output word_t out_y,
	output logic  out_zero,
	input  logic  out_ack,
	output logic  free
);

	hs_state_t state;

	assign out_req = (state == HS_BUSY);
	assign free    = (state == HS_IDLE);	// Ready for the next result

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= HS_IDLE;
		end else begin
			case (state)
				HS_IDLE: begin
					if (res_valid)
						state <= HS_BUSY;
				end
				HS_BUSY: begin
					if (out_ack)	// Sink took the data
						state <= HS_WAIT_DROP;
				end
				HS_WAIT_DROP: begin
					if (!out_ack)
						state <= HS_IDLE;
				end
				default: state <= HS_IDLE;
			endcase
		end
	end

	// Data stays put for the whole handshake
	always_ff @(posedge clk) begin
		if (state == HS_IDLE && res_valid) begin
			out_y    <= res_y;
			out_zero <= res_zero;
		end
	end

endmodule

// ==== src/exec_unit.sv ====
`timescale 1ns/1ps

module exec_unit import alu_pkg::*; (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    in_req,
	input  alu_op_t in_op,
	input  word_t   in_a,
	input  word_t   in_b,
	output logic    in_ack,
	output logic    out_req,
	output word_t   out_y,
	output logic    out_zero,
	input  logic    out_ack
);

	logic    start;
	alu_op_t op;
	word_t   a;
	word_t   b;
	word_t   hi;
	word_t   lo;
	logic    md_done;
	logic    res_valid;
	word_t   res_y;
	logic    res_zero;
	logic    free;

	op_capture u_capture (
		.clk(clk), .rst_n(rst_n), .in_req(in_req), .in_op(in_op), .in_a(in_a),
		.in_b(in_b), .in_ack(in_ack), .free(free), .start(start), .op(op), .a(a), .b(b)
	);

	alu_core u_alu (
		.clk(clk), .rst_n(rst_n), .start(start), .op(op), .a(a), .b(b), .hi(hi), .lo(lo),
		.md_done(md_done), .res_valid(res_valid), .res_y(res_y), .res_zero(res_zero)
	);

	muldiv_unit u_muldiv (
		.clk(clk), .rst_n(rst_n), .start(start), .op(op), .a(a), .b(b),
		.hi(hi), .lo(lo), .md_done(md_done)
	);

	result_sender u_sender (
		.clk(clk), .rst_n(rst_n), .res_valid(res_valid), .res_y(res_y),
		.res_zero(res_zero), .out_req(out_req), .out_y(out_y), .out_zero(out_zero),
		.out_ack(out_ack), .free(free)
	);

endmodule

// ==== tests/tb_exec_unit.sv ====
`timescale 1ns/1ps

module tb_exec_unit import alu_pkg::*; ();

	localparam int WAIT_LIMIT = 300;	// Cycles allowed per wait

	logic    clk, rst_n, in_req, in_ack, out_req, out_zero, out_ack;
	alu_op_t in_op;
	word_t   in_a, in_b, out_y;

	word_t   lcg_state;
	word_t   hi_m, lo_m;	// Shadow HI and LO
	alu_op_t op_q[$];
	word_t   a_q[$], b_q[$], exp_q[$];
	alu_op_t exp_op;	// Result the sink expects next
	word_t   exp_y;
	logic    exp_zero;
	logic    timed_out;
	int      err_cnt, chk_cnt, test_cnt;

	alu_op_t arith_ops[9] = '{OP_AND, OP_OR, OP_XOR, OP_ADDU, OP_SUBU,
		OP_SLTU, OP_SLT, OP_LUI, OP_JR};
	alu_op_t shift_ops[6] = '{OP_SLL, OP_SRL, OP_SRA, OP_SLLV, OP_SRLV, OP_SRAV};
	alu_op_t branch_ops[5] = '{OP_BLTZ, OP_BLTZAL, OP_BGTZ, OP_BEQZ, OP_BNEZ};

	exec_unit dut (
		.clk(clk), .rst_n(rst_n), .in_req(in_req), .in_op(in_op), .in_a(in_a), .in_b(in_b),
		.in_ack(in_ack), .out_req(out_req), .out_y(out_y), .out_zero(out_zero),
		.out_ack(out_ack)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic void note_error(input string msg);
		$display("%s", msg);
		err_cnt++;
	endfunction

	// Four-phase order on both sides
	assert property (@(posedge clk) disable iff (!rst_n) $rose(in_ack) |-> in_req && !out_req)
		else note_error($sformatf("in_ack rose without a request or under a held result at %0t",
			$time));
	assert property (@(posedge clk) disable iff (!rst_n) $fell(in_ack) |-> !in_req)
		else note_error($sformatf("in_ack fell before in_req was released at %0t", $time));
	assert property (@(posedge clk) disable iff (!rst_n) $rose(out_req) |-> !out_ack)
		else note_error($sformatf("out_req rose while out_ack was still high at %0t", $time));
	assert property (@(posedge clk) disable iff (!rst_n) $fell(out_req) |-> out_ack)
		else note_error($sformatf("out_req dropped without out_ack at %0t", $time));
	assert property (@(posedge clk) disable iff (!rst_n)
		out_req && $past(out_req) |-> $stable(out_y) && $stable(out_zero))
		else note_error($sformatf("ERR %0t: out_y or out_zero changed under out_req", $time));
	assert property (@(posedge clk) disable iff (!rst_n)
		$rose(out_req) |-> out_y == exp_y && out_zero == exp_zero)
		else note_error($sformatf("ERR %0t: %s gave y=%h zero=%b, expected y=%h zero=%b",
			$time, exp_op.name(), out_y, out_zero, exp_y, exp_zero));

	function automatic word_t rand_word();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic model_op(input alu_op_t op, input word_t a, input word_t b, output word_t y);
		logic signed [63:0] sa;
		logic signed [63:0] sb;
		shamt_t             sh_i;
		shamt_t             sh_v;
		sa   = {{32{a[31]}}, a};
		sb   = {{32{b[31]}}, b};
		sh_i = b[SHAMT_LSB +: 5];
		sh_v = b[4:0];
		y    = '0;
		case (op)
			OP_AND:   y = a & b;
			OP_OR:    y = a | b;
			OP_XOR:   y = a ^ b;
			OP_ADDU:  y = a + b;
			OP_SUBU:  y = a - b;
			OP_SLTU:  y = (a < b) ? 32'd1 : 32'd0;
			OP_SLT:   y = (sa < sb) ? 32'd1 : 32'd0;
			OP_SLL:   y = a << sh_i;
			OP_SRL:   y = a >> sh_i;
			OP_SRA:   y = word_t'(sa >>> sh_i);	// Sign already extended to 64
			OP_SLLV:  y = a << sh_v;
			OP_SRLV:  y = a >> sh_v;
			OP_SRAV:  y = word_t'(sa >>> sh_v);
			OP_MULTU: {hi_m, lo_m} = {32'd0, a} * {32'd0, b};
			OP_MULT:  {hi_m, lo_m} = sa * sb;
			OP_DIVU, OP_DIV: begin
				if (b == '0) begin
					lo_m = '1;
					hi_m = a;	// Dividend kept
				end else if (op == OP_DIVU) begin
					lo_m = a / b;
					hi_m = a % b;
				end else begin
					lo_m = word_t'(sa / sb);	// Truncates toward zero
					hi_m = word_t'(sa % sb);
				end
			end
			OP_MFHI:   y = hi_m;
			OP_MFLO:   y = lo_m;
			OP_BLTZ, OP_BLTZAL: y = (sa < 0) ? 32'd0 : 32'd1;
			OP_BGTZ:   y = (sa > 0) ? 32'd0 : 32'd1;
			OP_BEQZ:   y = (a == '0) ? 32'd0 : 32'd1;
			OP_BNEZ:   y = (a != '0) ? 32'd0 : 32'd1;
			OP_LUI:    y = {b[15:0], 16'd0};
			OP_JR:     y = a;
			default:   y = '0;
		endcase
		if (op == OP_MULTU || op == OP_MULT || op == OP_DIVU || op == OP_DIV)
			y = lo_m;	// New LO is returned
	endtask

	task automatic add_op(input alu_op_t op, input word_t a, input word_t b);
		word_t y;
		model_op(op, a, b, y);
		op_q.push_back(op);
		a_q.push_back(a);
		b_q.push_back(b);
		exp_q.push_back(y);
	endtask

	task automatic wait_until(input logic use_out, input logic level, input string what);
		int n;
		n = 0;
		do begin
			@(posedge clk);
			n++;
		end while (((use_out ? out_req : in_ack) != level) && n < WAIT_LIMIT);
		if ((use_out ? out_req : in_ack) != level) begin
			$display("Timeout at %0t while waiting for %s", $time, what);
			timed_out = 1'b1;
		end
	endtask

	task automatic send_op(input int k);
		@(posedge clk);
		in_op  <= op_q[k];
		in_a   <= a_q[k];
		in_b   <= b_q[k];
		in_req <= 1'b1;
		wait_until(1'b0, 1'b1, "in_ack to rise");
		in_req <= 1'b0;
		wait_until(1'b0, 1'b0, "in_ack to fall");
	endtask

	task automatic take_results(input int mask);
		int i;
		int d;
		for (i = 0; i < exp_q.size() && !timed_out; i++) begin
			exp_op   = op_q[i];
			exp_y    = exp_q[i];
			exp_zero = (exp_q[i] == '0);
			wait_until(1'b1, 1'b1, "out_req to rise");
			if (!timed_out) begin
				chk_cnt++;
				d = int'(rand_word() >> 24) & mask;	// Sink reaction time
				repeat (d) @(posedge clk);
				out_ack <= 1'b1;
				wait_until(1'b1, 1'b0, "out_req to fall");
				out_ack <= 1'b0;
			end
		end
	endtask

	task automatic run_test(input string name, input int mask);
		int errs;
		int i;
		errs = err_cnt;
		if (!timed_out) begin
			fork
				for (i = 0; i < op_q.size() && !timed_out; i++)
					send_op(i);
				take_results(mask);
			join
		end
		test_cnt++;
		$display("Test %0d %s: %0d ops, %0d errors", test_cnt, name, op_q.size(), err_cnt - errs);
		op_q.delete();
		a_q.delete();
		b_q.delete();
		exp_q.delete();
	endtask

	initial begin
		int    i;
		word_t a;
		word_t b;
		lcg_state = 32'h2eeb_a769;
		hi_m      = '0;
		lo_m      = '0;
		timed_out = 1'b0;
		err_cnt   = 0;
		chk_cnt   = 0;
		test_cnt  = 0;
		rst_n     = 1'b0;
		in_req    = 1'b0;
		in_op     = OP_AND;
		in_a      = '0;
		in_b      = '0;
		out_ack   = 1'b0;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		assert (!in_ack && !out_req)
			else note_error($sformatf("ERR %0t: in_ack or out_req high after reset", $time));

		for (i = 0; i < 4; i++)
			add_op(arith_ops[i], rand_word(), rand_word());
		run_test("handshake", 3);

		for (i = 0; i < 27; i++) begin
			a = rand_word();
			b = rand_word();
			a[31] = ((i / 9) % 3 == 1);	// Mixed sign bits
			b[31] = ((i / 9) % 3 == 2);
			add_op(arith_ops[i % 9], a, b);
		end
		run_test("logic_arith", 3);

		for (i = 0; i < 18; i++) begin
			a = rand_word();
			a[31] = ((i / 6) % 2 == 1);	// Negative a for sign fill
			add_op(shift_ops[i % 6], a, rand_word());
		end
		run_test("shifts", 3);

		for (i = 0; i < 25; i++) begin
			case (i / 5)
				0:       a = '0;
				1:       a = 32'd1;
				2:       a = '1;
				3:       a = 32'h8000_0000;
				default: a = rand_word();
			endcase
			add_op(branch_ops[i % 5], a, rand_word());
		end
		run_test("branches", 3);

		for (i = 0; i < 8; i++) begin
			a = rand_word();
			a[31] = (i % 4 >= 2);
			add_op((i % 2 == 1) ? OP_MULT : OP_MULTU, a, rand_word());
			add_op(OP_MFHI, '0, '0);
			add_op(OP_MFLO, '0, '0);
		end
		run_test("multiply", 3);

		for (i = 0; i < 10; i++) begin
			a = rand_word();
			b = (rand_word() >> 20) | 32'd1;	// Small odd divisor by default
			case (i / 2)
				0:       b = rand_word();
				1:       a[31] = 1'b1;
				2:       b = '0;
				3: begin
					a[31] = 1'b1;
					b     = -b;
				end
				default: b = -b;
			endcase
			add_op((i % 2 == 1) ? OP_DIV : OP_DIVU, a, b);
			add_op(OP_MFHI, '0, '0);
			add_op(OP_MFLO, '0, '0);
		end
		run_test("divide_slow_sink", 15);

		$display("Tests: %0d, results checked: %0d, errors: %0d", test_cnt, chk_cnt, err_cnt);
		if (err_cnt == 0 && !timed_out)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== project.f ====
src/alu_pkg.sv
src/op_capture.sv
src/alu_core.sv
src/muldiv_unit.sv
src/result_sender.sv
src/exec_unit.sv
tests/tb_exec_unit.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the exec_unit testbench with Verilator
cd "$(dirname "$0")" &&
	verilator --binary --timing --assert -f project.f --top-module tb_exec_unit -o sim_exec &&
	./obj_dir/sim_exec | tee /dev/stderr | grep -q "TEST PASSED" &&
	echo "Simulation passed" ||
	{ echo "Simulation failed"; exit 1; }
